//--- source/freq_meas_pkg.sv
/* Shared widths, bus structs, register map and FSM encoding for the frequency meter.
   Counter addresses 0x14..0x19 leave room for at most 6 measured clocks. */

package freq_meas_pkg;

    // ========================================
    // Widths and plain vector types
    // ========================================

    // Default counter width, also the width of the window limit
    localparam int COUNT_W = 40;

    typedef logic [4:0]         csr_addr_t;
    typedef logic [63:0]        csr_data_t;
    typedef logic [COUNT_W-1:0] count_t;

    // ========================================
    // Bus and control structs
    // ========================================

    // Host request, single-cycle strobes
    typedef struct packed {
        logic      read;
        logic      write;
        csr_addr_t address;
        csr_data_t writedata;
    } csr_req_t;

    // Response, both valids pulse one cycle after the strobe
    typedef struct packed {
        logic      readdatavalid;
        csr_data_t readdata;
        logic      writeresponsevalid;
    } csr_rsp_t;

    // Broadcast to every counter and the window timer
    typedef struct packed {
        logic clear;
        logic enable;
    } counter_ctrl_t;

    // Measurement sequencer states
    typedef enum logic [1:0] {
        MEAS_IDLE  = 2'd0,
        MEAS_CLEAR = 2'd1,
        MEAS_COUNT = 2'd2,
        MEAS_LIMIT = 2'd3
    } meas_state_t;

    // ========================================
    // Register map
    // ========================================

    localparam csr_addr_t ADDR_DFH        = 5'h00;
    localparam csr_addr_t ADDR_ID_LO      = 5'h01;
    localparam csr_addr_t ADDR_ID_HI      = 5'h02;
    localparam csr_addr_t ADDR_STATUS     = 5'h10;
    localparam csr_addr_t ADDR_CLEAR      = 5'h11;
    localparam csr_addr_t ADDR_ENABLE     = 5'h12;
    localparam csr_addr_t ADDR_MAX        = 5'h13;
    localparam csr_addr_t ADDR_COUNT_BASE = 5'h14;
    localparam csr_addr_t ADDR_REF_FREQ   = 5'h1a;

    // Feature header: type 1 in [63:60], end of list in bit 40
    localparam csr_data_t DFH_VALUE = 64'h1000_0100_0000_0000;

    // Block ID when the top level does not override it
    localparam logic [127:0] DEFAULT_ID = 128'h5a3c_1f29_84d6_4e07_b2c1_9e8f_6d04_a715;

endpackage

//--- source/clock_counter.sv
/* Edge counter for one measured clock. Clear must be held for a few count_clk cycles,
   and values read while a clear is crossing may be briefly incoherent. */

`timescale 1ns/1ps

module clock_counter
    import freq_meas_pkg::*;
#(
    parameter int COUNTER_WIDTH = COUNT_W
)
(
    input  logic          clk,
    input  logic          count_clk,
    input  logic          count_reset_n,
    input  counter_ctrl_t ctrl,
    output count_t        count
);

    // Measured clock domain
    counter_ctrl_t            ctrl_meta;
    counter_ctrl_t            ctrl_sync;
    logic [COUNTER_WIDTH-1:0] bin_q;
    logic [COUNTER_WIDTH-1:0] gray_q;

    // Reference clock domain
    logic [COUNTER_WIDTH-1:0] gray_meta;
    logic [COUNTER_WIDTH-1:0] gray_sync;

    // Gray back to binary, MSB first
    function automatic logic [COUNTER_WIDTH-1:0] gray_to_bin(
        input logic [COUNTER_WIDTH-1:0] g
    );
        logic [COUNTER_WIDTH-1:0] b;
        b[COUNTER_WIDTH-1] = g[COUNTER_WIDTH-1];
        for (int i = COUNTER_WIDTH - 2; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ========================================
    // count_clk side
    // ========================================

    // Two-flop synchronizer for the control pair
    always_ff @(posedge count_clk)
    begin
        if (!count_reset_n)
        begin
            ctrl_meta <= '0;
            ctrl_sync <= '0;
        end
        else
        begin
            ctrl_meta <= ctrl;
            ctrl_sync <= ctrl_meta;
        end
    end

    // Binary count plus registered Gray copy
    always_ff @(posedge count_clk)
    begin
        if (!count_reset_n || ctrl_sync.clear)
        begin
            bin_q  <= '0;
            gray_q <= '0;
        end
        else
        begin
            if (ctrl_sync.enable)
                bin_q <= bin_q + 1'b1;
            // One bit changes per step since bin_q moves by at most one
            gray_q <= bin_q ^ (bin_q >> 1);
        end
    end

    // ========================================
    // clk side
    // ========================================

    always_ff @(posedge clk)
    begin
        gray_meta <= gray_q;
        gray_sync <= gray_meta;
    end

    assign count = count_t'(gray_to_bin(gray_sync));

endmodule

//--- source/sample_window_timer.sv
/* Counts enabled clk cycles. A count_max of zero leaves the window unbounded. */

`timescale 1ns/1ps

module sample_window_timer
    import freq_meas_pkg::*;
#(
    parameter int COUNTER_WIDTH = COUNT_W
)
(
    input  logic          clk,
    input  logic          reset_n,
    input  counter_ctrl_t ctrl,
    input  count_t        count_max,
    output logic          window_done
);

    logic [COUNTER_WIDTH-1:0] cycle_cnt;
    logic [COUNTER_WIDTH-1:0] cycle_cnt_inc;

    // Cycle count including the current enabled cycle
    assign cycle_cnt_inc = cycle_cnt + 1'b1;

    always_ff @(posedge clk)
    begin
        if (!reset_n || ctrl.clear)
            cycle_cnt <= '0;
        else if (ctrl.enable)
            cycle_cnt <= cycle_cnt_inc;
    end

    // Last enabled cycle of the window
    // Enable drops on the next edge, leaving cycle_cnt at count_max
    assign window_done = ctrl.enable &&
                         (count_max != '0) &&
                         (count_t'(cycle_cnt_inc) == count_max);

endmodule

//--- source/measure_ctrl_fsm.sv
/* Measurement sequencer. Clear has priority over every other request. */

`timescale 1ns/1ps

module measure_ctrl_fsm
    import freq_meas_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  logic          clear_req,
    input  logic          enable_req,
    input  logic          window_done,
    output counter_ctrl_t ctrl,
    output logic          limit_reached
);

    meas_state_t state;
    meas_state_t state_next;

    // ========================================
    // Next state
    // ========================================

    always_comb
    begin
        state_next = state;
        if (clear_req)
            state_next = MEAS_CLEAR;
        else
        begin
            case (state)
                MEAS_IDLE,
                MEAS_CLEAR:
                    state_next = enable_req ? MEAS_COUNT : MEAS_IDLE;
                MEAS_COUNT:
                    if (!enable_req)
                        state_next = MEAS_IDLE;
                    else if (window_done)
                        state_next = MEAS_LIMIT;
                // Held until enable drops or a clear arrives
                MEAS_LIMIT:
                    if (!enable_req)
                        state_next = MEAS_IDLE;
                default:
                    state_next = MEAS_IDLE;
            endcase
        end
    end

    // Outputs registered with the state so the crossings see clean levels
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state         <= MEAS_IDLE;
            ctrl          <= '0;
            limit_reached <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            ctrl.clear    <= (state_next == MEAS_CLEAR);
            ctrl.enable   <= (state_next == MEAS_COUNT);
            limit_reached <= (state_next == MEAS_LIMIT);
        end
    end

endmodule

//--- source/csr_regfile.sv
/* Register file on a strobe bus with no waitrequest. Every strobe is answered one
   cycle later; unmapped addresses read zero and ignore writes. */

`timescale 1ns/1ps

module csr_regfile
    import freq_meas_pkg::*;
#(
    parameter int           N_CLOCKS      = 4,
    parameter int           COUNTER_WIDTH = COUNT_W,
    parameter int           REF_FREQ_MHZ  = 10,
    parameter logic [127:0] BLOCK_ID      = DEFAULT_ID
)
(
    input  logic                        clk,
    input  logic                        reset_n,
    input  csr_req_t                    csr_req,
    output csr_rsp_t                    csr_rsp,
    input  count_t [N_CLOCKS-1:0]       counts,
    input  logic                        limit_reached,
    output logic                        clear_req,
    output logic                        enable_req,
    output count_t                      count_max
);

    logic      rd_valid_q;
    logic      wr_valid_q;
    csr_data_t rd_data_q;
    csr_data_t rd_word;

    // ========================================
    // Writes and response strobes
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
            clear_req  <= 1'b0;
            enable_req <= 1'b0;
            count_max  <= '0;
        end
        else
        begin
            rd_valid_q <= csr_req.read;
            wr_valid_q <= csr_req.write;

            if (csr_req.write)
            begin
                case (csr_req.address)
                    ADDR_CLEAR:
                        clear_req <= csr_req.writedata[0];
                    ADDR_ENABLE:
                        enable_req <= csr_req.writedata[0];
                    // Limit keeps only the counter width
                    ADDR_MAX:
                        count_max <= count_t'(csr_req.writedata[COUNTER_WIDTH-1:0]);
                    default:
                        ;
                endcase
            end
        end
    end

    // ========================================
    // Read select
    // ========================================

    always_comb
    begin
        case (csr_req.address)
            ADDR_DFH:      rd_word = DFH_VALUE;
            ADDR_ID_LO:    rd_word = BLOCK_ID[63:0];
            ADDR_ID_HI:    rd_word = BLOCK_ID[127:64];
            ADDR_STATUS:   rd_word = 64'(limit_reached);
            ADDR_CLEAR:    rd_word = 64'(clear_req);
            ADDR_ENABLE:   rd_word = 64'(enable_req);
            ADDR_MAX:      rd_word = 64'(count_max);
            ADDR_REF_FREQ: rd_word = 64'(REF_FREQ_MHZ);
            default:       rd_word = '0;
        endcase

        // Counter window, one word per measured clock
        for (int i = 0; i < N_CLOCKS; i++)
        begin
            if (csr_req.address == csr_addr_t'(ADDR_COUNT_BASE + i))
                rd_word = 64'(counts[i]);
        end
    end

    // Read data only moves on a read strobe
    always_ff @(posedge clk)
    begin
        if (csr_req.read)
            rd_data_q <= rd_word;
    end

    assign csr_rsp = '{
        readdatavalid:      rd_valid_q,
        readdata:           rd_data_q,
        writeresponsevalid: wr_valid_q
    };

endmodule

//--- source/freq_meas_top.sv
/* Frequency meter top. N_CLOCKS is limited to 6 by the register map;
   each measured clock brings its own synchronous reset. */

`timescale 1ns/1ps

module freq_meas_top
    import freq_meas_pkg::*;
#(
    parameter int           N_CLOCKS      = 4,
    parameter int           COUNTER_WIDTH = COUNT_W,
    parameter int           REF_FREQ_MHZ  = 10,
    parameter logic [127:0] BLOCK_ID      = DEFAULT_ID
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  csr_req_t            csr_req,
    output csr_rsp_t            csr_rsp,
    input  logic [N_CLOCKS-1:0] meas_clk,
    input  logic [N_CLOCKS-1:0] meas_reset_n
);

    logic                  clear_req;
    logic                  enable_req;
    count_t                count_max;
    counter_ctrl_t         ctrl;
    logic                  limit_reached;
    logic                  window_done;
    count_t [N_CLOCKS-1:0] counts;

    // Host registers
    csr_regfile #(
        .N_CLOCKS      (N_CLOCKS),
        .COUNTER_WIDTH (COUNTER_WIDTH),
        .REF_FREQ_MHZ  (REF_FREQ_MHZ),
        .BLOCK_ID      (BLOCK_ID)
    ) csr_regfile_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_req       (csr_req),
        .csr_rsp       (csr_rsp),
        .counts        (counts),
        .limit_reached (limit_reached),
        .clear_req     (clear_req),
        .enable_req    (enable_req),
        .count_max     (count_max)
    );

    // Sequencer
    measure_ctrl_fsm measure_ctrl_fsm_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .clear_req     (clear_req),
        .enable_req    (enable_req),
        .window_done   (window_done),
        .ctrl          (ctrl),
        .limit_reached (limit_reached)
    );

    // Window length in reference cycles
    sample_window_timer #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) sample_window_timer_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .ctrl        (ctrl),
        .count_max   (count_max),
        .window_done (window_done)
    );

    // One counter per measured clock
    for (genvar i = 0; i < N_CLOCKS; i++)
    begin : gen_counter
        clock_counter #(
            .COUNTER_WIDTH (COUNTER_WIDTH)
        ) clock_counter_i (
            .clk           (clk),
            .count_clk     (meas_clk[i]),
            .count_reset_n (meas_reset_n[i]),
            .ctrl          (ctrl),
            .count         (counts[i])
        );
    end

endmodule

//--- verif/freq_meas_tb.sv
/* Frequency meter testbench with four measured clocks. Crossed counts are checked
   to +/-4 since synchronizer latency is a few cycles of each clock. */

`timescale 1ns/1ps

module freq_meas_tb
    import freq_meas_pkg::*;
();

    // ========================================
    // Test lengths and limits
    // ========================================

    localparam int REF_PERIOD_NS   = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int LIMIT_MIN       = 100;
    localparam int LIMIT_MAX       = 300;
    localparam int SETTLE_CYCLES   = 20;
    localparam int FREE_RUN_CYCLES = 150;
    localparam int BUS_OPS         = 40;
    localparam int TOLERANCE       = 4;
    localparam int RESP_TIMEOUT    = 4;
    localparam int CLEAR_POLLS     = 8;
    // About five times the summed length of all tests
    localparam int WATCHDOG_CYCLES = 5 * (RESET_CYCLES + LIMIT_MAX + FREE_RUN_CYCLES
                                          + 3 * SETTLE_CYCLES + 2 * BUS_OPS);
    localparam logic [127:0] TB_ID = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;

    logic       clk;
    logic       clk_200;
    logic       clk_400;
    logic       clk_70;
    logic       reset_n;
    logic [3:0] meas_reset_n;
    logic [3:0] meas_clk;
    csr_req_t   csr_req;
    csr_rsp_t   csr_rsp;
    integer     seed;
    int         error_count;
    int         check_count;
    int         test_count;
    int         test_fail_count;
    int         errors_at_start;
    string      test_name;

    // Clock 0 is the reference clock itself
    assign meas_clk = {clk_70, clk_400, clk_200, clk};

    freq_meas_top #(
        .N_CLOCKS      (4),
        .COUNTER_WIDTH (COUNT_W),
        .REF_FREQ_MHZ  (10),
        .BLOCK_ID      (TB_ID)
    ) freq_meas_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .csr_req      (csr_req),
        .csr_rsp      (csr_rsp),
        .meas_clk     (meas_clk),
        .meas_reset_n (meas_reset_n)
    );

    // ========================================
    // Clocks
    // ========================================

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        clk_200 = 1'b0;
        forever #100 clk_200 = ~clk_200;
    end

    initial
    begin
        clk_400 = 1'b0;
        forever #200 clk_400 = ~clk_400;
    end

    initial
    begin
        clk_70 = 1'b0;
        forever #35 clk_70 = ~clk_70;
    end

    // ========================================
    // Bus timing assertions
    // ========================================

    // Each valid equals its strobe one cycle earlier, so no stray pulses either
    read_response_timing: assert property (@(posedge clk) disable iff (!reset_n)
        csr_rsp.readdatavalid == $past(csr_req.read))
    else
    begin
        $display("readdatavalid did not follow a read strobe by one cycle at %0t", $time);
        error_count++;
    end

    write_response_timing: assert property (@(posedge clk) disable iff (!reset_n)
        csr_rsp.writeresponsevalid == $past(csr_req.write))
    else
    begin
        $display("writeresponsevalid did not follow a write strobe by one cycle at %0t", $time);
        error_count++;
    end

    // ========================================
    // Checks and bus tasks
    // ========================================

    task automatic check_equal(input string name, input csr_data_t expected,
                               input csr_data_t actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Crossed counts, allowed TOLERANCE either way
    task automatic check_near(input string name, input longint expected,
                              input csr_data_t actual);
        longint act;
        act = longint'(actual);
        check_count++;
        assert ((act >= expected - TOLERANCE) && (act <= expected + TOLERANCE))
        else
        begin
            $display("MISMATCH %s expected %h actual %h", name, expected, act);
            error_count++;
        end
    endtask

    // Called at the negedge after the strobe, the valid should already be up
    task automatic wait_response(input bit is_read, input csr_addr_t address);
        int waited;
        waited = 0;
        while (!(is_read ? csr_rsp.readdatavalid : csr_rsp.writeresponsevalid)
               && waited < RESP_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!(is_read ? csr_rsp.readdatavalid : csr_rsp.writeresponsevalid))
        begin
            $display("no %s response for address %h", is_read ? "read" : "write", address);
            error_count++;
        end
    endtask

    task automatic bus_write(input csr_addr_t address, input csr_data_t data);
        @(negedge clk);
        csr_req.write     = 1'b1;
        csr_req.address   = address;
        csr_req.writedata = data;
        @(negedge clk);
        csr_req.write = 1'b0;
        wait_response(1'b0, address);
    endtask

    task automatic bus_read(input csr_addr_t address, output csr_data_t data);
        @(negedge clk);
        csr_req.read    = 1'b1;
        csr_req.address = address;
        @(negedge clk);
        csr_req.read = 1'b0;
        wait_response(1'b1, address);
        data = csr_rsp.readdata;
    endtask

    task automatic read_check(input string name, input csr_addr_t address,
                              input csr_data_t expected);
        csr_data_t data;
        bus_read(address, data);
        check_equal(name, expected, data);
    endtask

    // Edges of a clock with the given period during a window of ref cycles
    function automatic longint ratio_count(input longint window, input int period_ns);
        return window * REF_PERIOD_NS / period_ns;
    endfunction

    function automatic int period_of(input int idx);
        case (idx)
            0:       return 100;
            1:       return 200;
            2:       return 400;
            default: return 70;
        endcase
    endfunction

    // Holds clear and polls until every counter reads zero; clear stays set
    task automatic clear_counters();
        csr_data_t data;
        int        polls;
        bit        all_zero;
        bus_write(ADDR_CLEAR, 64'h1);
        polls    = 0;
        all_zero = 1'b0;
        while (!all_zero && polls < CLEAR_POLLS)
        begin
            all_zero = 1'b1;
            for (int i = 0; i < 4; i++)
            begin
                bus_read(csr_addr_t'(ADDR_COUNT_BASE + i), data);
                if (data != '0)
                    all_zero = 1'b0;
            end
            polls++;
        end
        check_count++;
        assert (all_zero)
        else
        begin
            $display("counters did not clear within %0d polling rounds", CLEAR_POLLS);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start)
            $display("test %0d %s: ok", test_count, test_name);
        else
        begin
            $display("test %0d %s: %0d errors", test_count, test_name,
                     error_count - errors_at_start);
            test_fail_count++;
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================

    initial
    begin
        csr_data_t data;
        csr_data_t frozen [4];
        longint    limit;
        csr_req         = '0;
        reset_n         = 1'b0;
        meas_reset_n    = '0;
        seed            = 3187;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        test_fail_count = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n      = 1'b1;
        meas_reset_n = '1;

        // Header type 1 in the top nibble, end of list at bit 40
        begin_test("reset values");
        read_check("readdata dfh", ADDR_DFH, (64'd1 << 60) | (64'd1 << 40));
        read_check("readdata id_lo", ADDR_ID_LO, TB_ID[63:0]);
        read_check("readdata id_hi", ADDR_ID_HI, TB_ID[127:64]);
        read_check("readdata ref_freq", ADDR_REF_FREQ, 64'd10);
        end_test();

        begin_test("register readback");
        bus_write(ADDR_CLEAR, 64'h3);
        read_check("readdata clear", ADDR_CLEAR, 64'h1);
        bus_write(ADDR_CLEAR, 64'hffff_ffff_ffff_fffe);
        read_check("readdata clear", ADDR_CLEAR, 64'h0);
        bus_write(ADDR_ENABLE, 64'h5);
        read_check("readdata enable", ADDR_ENABLE, 64'h1);
        bus_write(ADDR_ENABLE, 64'h2);
        read_check("readdata enable", ADDR_ENABLE, 64'h0);
        // Only the low 40 bits are kept
        bus_write(ADDR_MAX, 64'habcd_1234_5678_9abc);
        read_check("readdata max", ADDR_MAX, 64'h0000_0034_5678_9abc);
        bus_write(5'h05, 64'hdead_beef_0123_4567);
        read_check("readdata unmapped", 5'h05, 64'h0);
        end_test();

        begin_test("counter clear");
        clear_counters();
        read_check("readdata status", ADDR_STATUS, 64'h0);
        bus_write(ADDR_CLEAR, 64'h0);
        end_test();

        begin_test("bounded window");
        limit = LIMIT_MIN + ($unsigned($random(seed)) % (LIMIT_MAX - LIMIT_MIN + 1));
        bus_write(ADDR_MAX, csr_data_t'(limit));
        clear_counters();
        // Enable while clear is held, then releasing clear starts the window
        bus_write(ADDR_ENABLE, 64'h1);
        bus_write(ADDR_CLEAR, 64'h0);
        repeat (limit + SETTLE_CYCLES) @(negedge clk);
        read_check("readdata status", ADDR_STATUS, 64'h1);
        read_check("count[0]", ADDR_COUNT_BASE, csr_data_t'(limit));
        for (int i = 1; i < 4; i++)
        begin
            bus_read(csr_addr_t'(ADDR_COUNT_BASE + i), data);
            check_near($sformatf("count[%0d]", i), ratio_count(limit, period_of(i)), data);
        end
        end_test();

        begin_test("unbounded run");
        bus_write(ADDR_ENABLE, 64'h0);
        bus_write(ADDR_MAX, 64'h0);
        clear_counters();
        bus_write(ADDR_CLEAR, 64'h0);
        bus_write(ADDR_ENABLE, 64'h1);
        repeat (FREE_RUN_CYCLES) @(negedge clk);
        bus_write(ADDR_ENABLE, 64'h0);
        repeat (SETTLE_CYCLES) @(negedge clk);
        for (int i = 0; i < 4; i++)
            bus_read(csr_addr_t'(ADDR_COUNT_BASE + i), frozen[i]);
        read_check("readdata status", ADDR_STATUS, 64'h0);
        repeat (SETTLE_CYCLES) @(negedge clk);
        for (int i = 0; i < 4; i++)
        begin
            bus_read(csr_addr_t'(ADDR_COUNT_BASE + i), data);
            check_equal($sformatf("count[%0d] frozen", i), frozen[i], data);
            // Strobe to strobe is two cycles longer than the wait
            check_near($sformatf("count[%0d]", i),
                       ratio_count(FREE_RUN_CYCLES + 2, period_of(i)), data);
        end
        read_check("readdata status", ADDR_STATUS, 64'h0);
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, test_fail_count, check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d clk cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- sim.f
source/freq_meas_pkg.sv
source/clock_counter.sv
source/sample_window_timer.sv
source/measure_ctrl_fsm.sv
source/csr_regfile.sv
source/freq_meas_top.sv
verif/freq_meas_tb.sv
